// ==== hw/sdram_sched_pkg.sv ====
/*
 * Shared definitions of the SDRAM command scheduler
 * Device geometry and timer width, command pin encodings, bank state
 * Address union, command bus, host request and bank readiness structs
 */
`default_nettype none

package sdram_sched_pkg;

  // Device geometry
  localparam int BA_W    = 2;
  localparam int ROW_W   = 11;
  localparam int COL_W   = 8;
  localparam int DQ_W    = 16;
  localparam int BANKS   = 4;
  localparam int TIMER_W = 6;

  // Command pins {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_e;

  typedef enum logic {
    BANK_IDLE = 1'b0,
    BANK_OPEN = 1'b1
  } bank_state_e;

  // Address pins during RD, WR and PRE
  typedef struct packed {
    logic                   all_banks;  // A10
    logic [ROW_W-COL_W-2:0] rsvd;
    logic [COL_W-1:0]       col;
  } sdram_cas_addr_t;

  // Same pins, row view for ACT
  typedef union packed {
    logic [ROW_W-1:0] row;
    sdram_cas_addr_t  cas;
  } sdram_addr_u;

  typedef struct packed {
    sdram_cmd_e       cmd;
    logic [BA_W-1:0]  ba;
    sdram_addr_u      addr;
  } sdram_bus_t;

  typedef struct packed {
    logic             we;
    logic [BA_W-1:0]  ba;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [DQ_W-1:0]  wdata;
  } host_req_t;

  // Per-bank permissions, plus the shared refresh permission
  typedef struct packed {
    logic [BANKS-1:0] act_ok;
    logic [BANKS-1:0] rdwr_ok;
    logic [BANKS-1:0] pre_ok;
    logic             ref_ok;
  } bank_ready_t;

endpackage

`default_nettype wire

// ==== hw/sdram_bank_timers.sv ====
/*
 * SDRAM timing down-counters
 * tRCD, tRAS, tRP and tWR per bank, tRFC shared
 * Done flags are combined into per-bank command permissions
 */
`default_nettype none

module sdram_bank_timers #(
  parameter int T_RCD = 2,
  parameter int T_RP  = 2,
  parameter int T_RAS = 4,
  parameter int T_WR  = 2,
  parameter int T_RFC = 6
) (
  input  wire                                  clk_i,
  input  wire                                  rst_ni,
  input  wire                                  issue_act_i,
  input  wire                                  issue_wr_i,
  input  wire                                  issue_pre_i,
  input  wire                                  issue_ref_i,
  input  wire                                  pre_all_i,
  input  wire  [sdram_sched_pkg::BA_W-1:0]     issue_ba_i,
  output sdram_sched_pkg::bank_ready_t         ready_o
);

  localparam int TW      = sdram_sched_pkg::TIMER_W;
  localparam int BANKS   = sdram_sched_pkg::BANKS;
  localparam int BA_W    = sdram_sched_pkg::BA_W;

  // Counter index layout, one group of BANKS per constraint
  localparam int IDX_RCD = 0;
  localparam int IDX_RAS = BANKS;
  localparam int IDX_RP  = 2 * BANKS;
  localparam int IDX_WR  = 3 * BANKS;
  localparam int IDX_RFC = 4 * BANKS;
  localparam int NUM_CNT = 4 * BANKS + 1;

  // Command visible one cycle after its strobe, so count one less
  function automatic logic [TW-1:0] load_of(input int t);
    logic [TW-1:0] v;
    v = (t > 1) ? TW'(t - 1) : '0;
    return v;
  endfunction

  logic [NUM_CNT-1:0] load;
  logic [TW-1:0]      load_val [NUM_CNT];
  logic [TW-1:0]      cnt      [NUM_CNT];
  logic [NUM_CNT-1:0] done;

  always_comb
  begin
    for (int b = 0; b < BANKS; b++)
    begin
      load[IDX_RCD + b]     = issue_act_i && (issue_ba_i == BA_W'(b));
      load[IDX_RAS + b]     = issue_act_i && (issue_ba_i == BA_W'(b));
      load[IDX_RP + b]      = issue_pre_i && (pre_all_i || issue_ba_i == BA_W'(b));
      load[IDX_WR + b]      = issue_wr_i && (issue_ba_i == BA_W'(b));
      load_val[IDX_RCD + b] = load_of(T_RCD);
      load_val[IDX_RAS + b] = load_of(T_RAS);
      load_val[IDX_RP + b]  = load_of(T_RP);
      load_val[IDX_WR + b]  = load_of(T_WR);
    end
    load[IDX_RFC]     = issue_ref_i;
    load_val[IDX_RFC] = load_of(T_RFC);
  end

  //////////////////////////////
  // Down-counters
  for (genvar i = 0; i < NUM_CNT; i++)
  begin : g_cnt
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        cnt[i]  <= '0;
        done[i] <= 1'b1;
      end
      else if (load[i])
      begin
        cnt[i]  <= load_val[i];
        done[i] <= load_val[i] == '0;
      end
      else if (!done[i])
      begin
        cnt[i]  <= cnt[i] - 1'b1;
        done[i] <= cnt[i] == TW'(1);
      end
    end
  end

  //////////////////////////////
  // Permissions, all held off during tRFC
  always_comb
  begin
    for (int b = 0; b < BANKS; b++)
    begin
      ready_o.act_ok[b]  = done[IDX_RP + b] & done[IDX_RFC];
      ready_o.rdwr_ok[b] = done[IDX_RCD + b] & done[IDX_RFC];
      ready_o.pre_ok[b]  = done[IDX_RAS + b] & done[IDX_WR + b] & done[IDX_RFC];
    end
    ready_o.ref_ok = (&done[IDX_RP +: BANKS]) & done[IDX_RFC];
  end

endmodule

`default_nettype wire

// ==== hw/sdram_refresh_timer.sv ====
/*
 * Refresh interval counter and pending-refresh count
 */
`default_nettype none

module sdram_refresh_timer #(
  parameter int REFRESH_INTERVAL = 780
) (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  issue_ref_i,
  output logic refresh_due_o
);

  localparam int IVL_W  = $clog2(REFRESH_INTERVAL + 1);
  localparam int PEND_W = 2;

  logic [IVL_W-1:0]  interval_cnt;
  logic              expire;
  logic [PEND_W-1:0] pending;

  assign expire = interval_cnt == '0;

  // Free running, one expiry per interval
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      interval_cnt <= IVL_W'(REFRESH_INTERVAL - 1);
    else if (expire)
      interval_cnt <= IVL_W'(REFRESH_INTERVAL - 1);
    else
      interval_cnt <= interval_cnt - 1'b1;
  end

  // Saturates when refreshes are held off too long
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pending <= '0;
    else
      case ({expire, issue_ref_i && pending != '0})
        2'b10:   if (pending != '1) pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: ;
      endcase
  end

  assign refresh_due_o = pending != '0;

endmodule

`default_nettype wire

// ==== hw/sdram_bank_table.sv ====
/*
 * Open-row table, one state flag and row register per bank
 * Row-hit and open decode for the requested bank
 */
`default_nettype none

module sdram_bank_table (
  input  wire                               clk_i,
  input  wire                               rst_ni,
  input  wire                               issue_act_i,
  input  wire                               issue_pre_i,
  input  wire                               pre_all_i,
  input  wire  [sdram_sched_pkg::BA_W-1:0]  issue_ba_i,
  input  wire  [sdram_sched_pkg::ROW_W-1:0] issue_row_i,
  input  wire  [sdram_sched_pkg::BA_W-1:0]  req_ba_i,
  input  wire  [sdram_sched_pkg::ROW_W-1:0] req_row_i,
  output logic                              row_hit_o,
  output logic                              bank_open_o,
  output logic                              any_open_o
);

  localparam int BANKS = sdram_sched_pkg::BANKS;

  sdram_sched_pkg::bank_state_e            state [BANKS];
  logic [sdram_sched_pkg::ROW_W-1:0]       row   [BANKS];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      for (int b = 0; b < BANKS; b++)
        state[b] <= sdram_sched_pkg::BANK_IDLE;
    else
      for (int b = 0; b < BANKS; b++)
        if (issue_pre_i && (pre_all_i || issue_ba_i == b[sdram_sched_pkg::BA_W-1:0]))
          state[b] <= sdram_sched_pkg::BANK_IDLE;
        else if (issue_act_i && issue_ba_i == b[sdram_sched_pkg::BA_W-1:0])
          state[b] <= sdram_sched_pkg::BANK_OPEN;
  end

  // Row only meaningful while the bank is open
  always_ff @(posedge clk_i)
  begin
    if (issue_act_i)
      row[issue_ba_i] <= issue_row_i;
  end

  assign bank_open_o = state[req_ba_i] == sdram_sched_pkg::BANK_OPEN;
  assign row_hit_o   = bank_open_o && (row[req_ba_i] == req_row_i);

  always_comb
  begin
    any_open_o = 1'b0;
    for (int b = 0; b < BANKS; b++)
      any_open_o = any_open_o | (state[b] == sdram_sched_pkg::BANK_OPEN);
  end

endmodule

`default_nettype wire

// ==== hw/sdram_cmd_fsm.sv ====
/*
 * Command FSM, picks one SDRAM command per cycle
 * Refresh sequencing, row miss handling, RD/WR with host acknowledge
 * Registered command bus and write data drive
 */
`default_nettype none

module sdram_cmd_fsm (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire                                 req_i,
  input  wire  sdram_sched_pkg::host_req_t    req_data_i,
  input  wire  sdram_sched_pkg::bank_ready_t  ready_i,
  input  wire                                 row_hit_i,
  input  wire                                 bank_open_i,
  input  wire                                 any_open_i,
  input  wire                                 refresh_due_i,
  output logic                                issue_act_o,
  output logic                                issue_rd_o,
  output logic                                issue_wr_o,
  output logic                                issue_pre_o,
  output logic                                issue_ref_o,
  output logic                                pre_all_o,
  output sdram_sched_pkg::sdram_bus_t         sdram_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]    sdram_dq_o,
  output logic                                sdram_dqoe_o,
  output logic                                req_ack_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRECHARGE_ALL,
    ST_REFRESH
  } state_e;

  state_e                      state, state_nxt;
  sdram_sched_pkg::sdram_bus_t bus_nxt;
  logic                        req_pending;

  // Acked request is still on the port for one more cycle
  assign req_pending = req_i & ~req_ack_o;

  //////////////////////////////
  // Next command decision
  always_comb
  begin
    state_nxt   = state;
    issue_act_o = 1'b0;
    issue_rd_o  = 1'b0;
    issue_wr_o  = 1'b0;
    issue_pre_o = 1'b0;
    issue_ref_o = 1'b0;
    pre_all_o   = 1'b0;

    case (state)
      ST_IDLE:
        if (refresh_due_i)
        begin
          if (any_open_i)
            state_nxt = ST_PRECHARGE_ALL;
          else if (ready_i.ref_ok)
            issue_ref_o = 1'b1;
        end
        else if (req_pending)
        begin
          if (row_hit_i)
          begin
            if (ready_i.rdwr_ok[req_data_i.ba])
            begin
              issue_wr_o = req_data_i.we;
              issue_rd_o = ~req_data_i.we;
            end
          end
          // Wrong row open, close it first
          else if (bank_open_i)
            issue_pre_o = ready_i.pre_ok[req_data_i.ba];
          else
            issue_act_o = ready_i.act_ok[req_data_i.ba];
        end

      ST_PRECHARGE_ALL:
        if (&ready_i.pre_ok)
        begin
          issue_pre_o = 1'b1;
          pre_all_o   = 1'b1;
          state_nxt   = ST_REFRESH;
        end

      ST_REFRESH:
        if (ready_i.ref_ok)
        begin
          issue_ref_o = 1'b1;
          state_nxt   = ST_IDLE;
        end

      default: state_nxt = ST_IDLE;
    endcase
  end

  // Command bus contents for the chosen strobe
  always_comb
  begin
    bus_nxt.cmd  = sdram_sched_pkg::CMD_NOP;
    bus_nxt.ba   = req_data_i.ba;
    bus_nxt.addr = '0;

    if (issue_act_o)
    begin
      bus_nxt.cmd      = sdram_sched_pkg::CMD_ACT;
      bus_nxt.addr.row = req_data_i.row;
    end
    else if (issue_rd_o || issue_wr_o)
    begin
      bus_nxt.cmd                = issue_wr_o ? sdram_sched_pkg::CMD_WR
                                              : sdram_sched_pkg::CMD_RD;
      bus_nxt.addr.cas.all_banks = 1'b0;
      bus_nxt.addr.cas.rsvd      = '0;
      bus_nxt.addr.cas.col       = req_data_i.col;
    end
    else if (issue_pre_o)
    begin
      bus_nxt.cmd                = sdram_sched_pkg::CMD_PRE;
      bus_nxt.addr.cas.all_banks = pre_all_o;
    end
    else if (issue_ref_o)
      bus_nxt.cmd = sdram_sched_pkg::CMD_REF;
  end

  //////////////////////////////
  // Registers
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state        <= ST_IDLE;
      sdram_o.cmd  <= sdram_sched_pkg::CMD_NOP;
      sdram_o.ba   <= '0;
      sdram_o.addr <= '0;
      sdram_dqoe_o <= 1'b0;
      req_ack_o    <= 1'b0;
    end
    else
    begin
      state        <= state_nxt;
      sdram_o      <= bus_nxt;
      sdram_dqoe_o <= issue_wr_o;
      req_ack_o    <= issue_rd_o | issue_wr_o;
    end
  end

  // Write word lines up with the WR cycle
  always_ff @(posedge clk_i)
  begin
    if (issue_wr_o)
      sdram_dq_o <= req_data_i.wdata;
  end

endmodule

`default_nettype wire

// ==== hw/sdram_read_tracker.sv ====
/*
 * Read return tracking
 * Valid-bit shift queue covering the CAS latency, read data capture
 */
`default_nettype none

module sdram_read_tracker #(
  parameter int CAS_LATENCY = 2
) (
  input  wire                               clk_i,
  input  wire                               rst_ni,
  input  wire                               issue_rd_i,
  input  wire  [sdram_sched_pkg::DQ_W-1:0]  sdram_dq_i,
  output logic [sdram_sched_pkg::DQ_W-1:0]  rdata_o,
  output logic                              rdata_valid_o
);

  // Strobe one cycle ahead of the visible RD, data CAS_LATENCY after it
  localparam int DEPTH = CAS_LATENCY + 1;

  logic [DEPTH-1:0] rd_queue;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rd_queue <= '0;
    else
    begin
      for (int i = 0; i < DEPTH - 1; i++)
        rd_queue[i] <= rd_queue[i+1];
      rd_queue[DEPTH-1] <= issue_rd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rdata_valid_o <= 1'b0;
    else
      rdata_valid_o <= rd_queue[0];
  end

  // Head valid marks the cycle the device drives DQ
  always_ff @(posedge clk_i)
  begin
    if (rd_queue[0])
      rdata_o <= sdram_dq_i;
  end

endmodule

`default_nettype wire

// ==== hw/sdram_sched_top.sv ====
/*
 * Single-port SDRAM command scheduler, top level
 * Command FSM, bank timers, open-row table, refresh timer, read tracker
 */
`default_nettype none

module sdram_sched_top #(
  parameter int T_RCD            = 2,
  parameter int T_RP             = 2,
  parameter int T_RAS            = 4,
  parameter int T_WR             = 2,
  parameter int T_RFC            = 6,
  parameter int CAS_LATENCY      = 2,
  parameter int REFRESH_INTERVAL = 780
) (
  input  wire                                clk_i,
  input  wire                                rst_ni,
  input  wire                                req_i,
  input  wire  sdram_sched_pkg::host_req_t   req_data_i,
  output logic                               req_ack_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]   rdata_o,
  output logic                               rdata_valid_o,
  output sdram_sched_pkg::sdram_bus_t        sdram_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]   sdram_dq_o,
  output logic                               sdram_dqoe_o,
  input  wire  [sdram_sched_pkg::DQ_W-1:0]   sdram_dq_i
);

  // Command strobes from the FSM
  logic issue_act;
  logic issue_rd;
  logic issue_wr;
  logic issue_pre;
  logic issue_ref;
  logic pre_all;

  sdram_sched_pkg::bank_ready_t ready;
  logic                         row_hit;
  logic                         bank_open;
  logic                         any_open;
  logic                         refresh_due;

  sdram_cmd_fsm sdram_cmd_fsm_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_data_i    (req_data_i),
    .ready_i       (ready),
    .row_hit_i     (row_hit),
    .bank_open_i   (bank_open),
    .any_open_i    (any_open),
    .refresh_due_i (refresh_due),
    .issue_act_o   (issue_act),
    .issue_rd_o    (issue_rd),
    .issue_wr_o    (issue_wr),
    .issue_pre_o   (issue_pre),
    .issue_ref_o   (issue_ref),
    .pre_all_o     (pre_all),
    .sdram_o       (sdram_o),
    .sdram_dq_o    (sdram_dq_o),
    .sdram_dqoe_o  (sdram_dqoe_o),
    .req_ack_o     (req_ack_o)
  );

  // ACT and PRE always target the requested bank
  sdram_bank_timers #(
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_RAS (T_RAS),
    .T_WR  (T_WR),
    .T_RFC (T_RFC)
  ) sdram_bank_timers_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_act_i (issue_act),
    .issue_wr_i  (issue_wr),
    .issue_pre_i (issue_pre),
    .issue_ref_i (issue_ref),
    .pre_all_i   (pre_all),
    .issue_ba_i  (req_data_i.ba),
    .ready_o     (ready)
  );

  sdram_bank_table sdram_bank_table_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_act_i (issue_act),
    .issue_pre_i (issue_pre),
    .pre_all_i   (pre_all),
    .issue_ba_i  (req_data_i.ba),
    .issue_row_i (req_data_i.row),
    .req_ba_i    (req_data_i.ba),
    .req_row_i   (req_data_i.row),
    .row_hit_o   (row_hit),
    .bank_open_o (bank_open),
    .any_open_o  (any_open)
  );

  sdram_refresh_timer #(
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) sdram_refresh_timer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_ref_i   (issue_ref),
    .refresh_due_o (refresh_due)
  );

  sdram_read_tracker #(
    .CAS_LATENCY (CAS_LATENCY)
  ) sdram_read_tracker_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_rd_i    (issue_rd),
    .sdram_dq_i    (sdram_dq_i),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
/*
 * Free-running testbench clock
 */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 20
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== verification/sdram_sched_tb.sv ====
/*
 * Testbench of the SDRAM command scheduler
 * Stimulus reader and host driver, SDRAM device model with open-row tracking
 * Command spacing, refresh, write data and read return checks
 */
`default_nettype none

module sdram_sched_tb;

  localparam int T_RCD            = 2;
  localparam int T_RP             = 2;
  localparam int T_RAS            = 4;
  localparam int T_WR             = 2;
  localparam int T_RFC            = 6;
  localparam int CAS_LATENCY      = 2;
  localparam int REFRESH_INTERVAL = 200;
  localparam int BANKS            = sdram_sched_pkg::BANKS;
  localparam int STIM_MAX         = 32;
  localparam int ACK_TIMEOUT      = 100;

  logic                                clk;
  logic                                rst_n;
  logic                                req;
  sdram_sched_pkg::host_req_t          req_data;
  logic                                req_ack;
  logic [sdram_sched_pkg::DQ_W-1:0]    rdata;
  logic                                rdata_valid;
  sdram_sched_pkg::sdram_bus_t         sdram_bus;
  logic [sdram_sched_pkg::DQ_W-1:0]    sdram_dq_out;
  logic                                sdram_dqoe;
  logic [sdram_sched_pkg::DQ_W-1:0]    sdram_dq_in;
  logic [15:0]                         exp_rdata;

  // Six words per request: we, ba, row, col, wdata, expected read data
  logic [15:0] stim_mem [6*STIM_MAX];

  // Device model and monitor state
  int          cyc;
  int          last_act [BANKS];
  int          last_pre [BANKS];
  int          last_wr  [BANKS];
  int          last_ref;
  int          ref_mark;
  int          ref_cnt;
  int          pre_all_cnt;
  bit          bank_open_m [BANKS];
  logic [10:0] bank_row_m  [BANKS];
  logic [15:0] mem_model [logic [20:0]];
  int          dq_due_q[$];
  logic [15:0] dq_data_q[$];
  int          rd_due_q[$];
  logic [15:0] rd_exp_q[$];
  bit          req_seen;
  bit          active;
  bit          hit_at_start;
  bit          miss_at_start;
  bit          ref_in_req;
  int          act_in_req;
  int          pre_in_req;
  logic [20:0] key;

  sdram_sched_pkg::sdram_cmd_e cmd;

  tb_clock_gen #(
    .PERIOD (20)
  ) tb_clock_gen_inst (
    .clk_o (clk)
  );

  sdram_sched_top #(
    .T_RCD            (T_RCD),
    .T_RP             (T_RP),
    .T_RAS            (T_RAS),
    .T_WR             (T_WR),
    .T_RFC            (T_RFC),
    .CAS_LATENCY      (CAS_LATENCY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) sdram_sched_top_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (req),
    .req_data_i    (req_data),
    .req_ack_o     (req_ack),
    .rdata_o       (rdata),
    .rdata_valid_o (rdata_valid),
    .sdram_o       (sdram_bus),
    .sdram_dq_o    (sdram_dq_out),
    .sdram_dqoe_o  (sdram_dqoe),
    .sdram_dq_i    (sdram_dq_in)
  );

  //////////////////////////////
  // Helpers

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      report_failure($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Unwritten locations return a word built from the whole address
  function automatic logic [15:0] fill_word(input logic [20:0] addr);
    return addr[15:0] ^ {addr[20:16], addr[20:16], addr[20:16], addr[20]};
  endfunction

  task automatic wait_for_ack(input int idx);
    int n;
    n = 0;
    @(posedge clk);
    while (!req_ack)
    begin
      n++;
      if (n > ACK_TIMEOUT)
        report_failure($sformatf("Timeout waiting for req_ack_o on request %0d", idx));
      @(posedge clk);
    end
  endtask

  //////////////////////////////
  // SDRAM model and protocol monitor
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      cyc         = 0;
      last_ref    = -1000;
      ref_mark    = 0;
      ref_cnt     = 0;
      pre_all_cnt = 0;
      req_seen    = 1'b0;
      active      = 1'b0;
      for (int b = 0; b < BANKS; b++)
      begin
        last_act[b]    = -1000;
        last_pre[b]    = -1000;
        last_wr[b]     = -1000;
        bank_open_m[b] = 1'b0;
      end
    end
    else
    begin
      cyc = cyc + 1;
      cmd = sdram_bus.cmd;

      // Quiet bus until the host asks for something
      if (req)
        req_seen = 1'b1;
      else if (!req_seen)
      begin
        check_value("idle command after reset", sdram_sched_pkg::CMD_NOP, cmd);
        check_value("idle req_ack_o", 0, req_ack);
        check_value("idle rdata_valid_o", 0, rdata_valid);
        check_value("idle sdram_dqoe_o", 0, sdram_dqoe);
      end

      // Row state seen by a new request
      if (req && !active)
      begin
        active        = 1'b1;
        hit_at_start  = bank_open_m[req_data.ba] && bank_row_m[req_data.ba] == req_data.row;
        miss_at_start = bank_open_m[req_data.ba] && bank_row_m[req_data.ba] != req_data.row;
        ref_in_req    = 1'b0;
        act_in_req    = 0;
        pre_in_req    = 0;
      end

      check_value("dqoe only in WR cycle", cmd == sdram_sched_pkg::CMD_WR, sdram_dqoe);
      check_value("ack with RD or WR", cmd == sdram_sched_pkg::CMD_RD ||
                  cmd == sdram_sched_pkg::CMD_WR, req_ack);

      case (cmd)
        sdram_sched_pkg::CMD_NOP: ;

        sdram_sched_pkg::CMD_ACT:
        begin
          if (bank_open_m[sdram_bus.ba])
            report_failure("ACT issued to a bank that is already open");
          if (cyc - last_pre[sdram_bus.ba] < T_RP)
            report_failure("PRE to ACT spacing shorter than tRP");
          if (cyc - last_ref < T_RFC)
            report_failure("REF to ACT spacing shorter than tRFC");
          bank_open_m[sdram_bus.ba] = 1'b1;
          bank_row_m[sdram_bus.ba]  = sdram_bus.addr.row;
          last_act[sdram_bus.ba]    = cyc;
          act_in_req++;
        end

        sdram_sched_pkg::CMD_PRE:
        begin
          if (cyc - last_ref < T_RFC)
            report_failure("REF to PRE spacing shorter than tRFC");
          for (int b = 0; b < BANKS; b++)
            if (sdram_bus.addr.cas.all_banks || sdram_bus.ba == b)
            begin
              if (cyc - last_act[b] < T_RAS)
                report_failure("ACT to PRE spacing shorter than tRAS");
              if (cyc - last_wr[b] < T_WR)
                report_failure("WR to PRE spacing shorter than tWR");
              bank_open_m[b] = 1'b0;
              last_pre[b]    = cyc;
            end
          if (sdram_bus.addr.cas.all_banks)
            pre_all_cnt++;
          pre_in_req++;
        end

        sdram_sched_pkg::CMD_RD, sdram_sched_pkg::CMD_WR:
        begin
          if (!req)
            report_failure("RD or WR issued with no request pending");
          check_value("command bank", req_data.ba, sdram_bus.ba);
          check_value("command column", req_data.col, sdram_bus.addr.cas.col);
          check_value("write flag", req_data.we, cmd == sdram_sched_pkg::CMD_WR);
          if (!bank_open_m[req_data.ba] || bank_row_m[req_data.ba] != req_data.row)
            report_failure("RD or WR issued to a bank without the request row open");
          if (cyc - last_act[req_data.ba] < T_RCD)
            report_failure("ACT to RD or WR spacing shorter than tRCD");
          if (cyc - last_ref < T_RFC)
            report_failure("REF to RD or WR spacing shorter than tRFC");
          key = {req_data.ba, req_data.row, req_data.col};
          if (cmd == sdram_sched_pkg::CMD_WR)
          begin
            check_value("write data", req_data.wdata, sdram_dq_out);
            mem_model[key]      = sdram_dq_out;
            last_wr[req_data.ba] = cyc;
          end
          else
          begin
            dq_due_q.push_back(cyc + CAS_LATENCY);
            dq_data_q.push_back(mem_model.exists(key) ? mem_model[key] : fill_word(key));
            rd_due_q.push_back(cyc + CAS_LATENCY + 1);
            rd_exp_q.push_back(exp_rdata);
          end
          // A refresh in between may close the row
          if (!ref_in_req)
          begin
            if (hit_at_start)
              check_value("ACT count on row hit", 0, act_in_req);
            if (miss_at_start)
            begin
              check_value("PRE count on row miss", 1, pre_in_req);
              check_value("ACT count on row miss", 1, act_in_req);
            end
          end
          active = 1'b0;
        end

        sdram_sched_pkg::CMD_REF:
        begin
          if (cyc - last_ref < T_RFC)
            report_failure("REF to REF spacing shorter than tRFC");
          for (int b = 0; b < BANKS; b++)
            if (bank_open_m[b])
              report_failure("REF issued while a bank is open");
          last_ref   = cyc;
          ref_mark   = cyc;
          ref_cnt++;
          ref_in_req = 1'b1;
        end

        default: report_failure("Unknown command code on the SDRAM bus");
      endcase

      if (cyc - ref_mark > REFRESH_INTERVAL + 40)
        report_failure("No REF seen within the refresh interval");

      // Read return, CAS_LATENCY+1 after the visible RD
      if (rdata_valid)
      begin
        if (rd_due_q.size() == 0 || rd_due_q[0] != cyc)
          report_failure("rdata_valid_o without a matching RD");
        check_value("read data", rd_exp_q[0], rdata);
        void'(rd_due_q.pop_front());
        void'(rd_exp_q.pop_front());
      end
      else if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc)
        report_failure("rdata_valid_o missing after RD");

      // Device drives DQ in the next cycle if a read is due
      if (dq_due_q.size() != 0 && dq_due_q[0] == cyc + 1)
      begin
        void'(dq_due_q.pop_front());
        sdram_dq_in <= dq_data_q.pop_front();
      end
      else
        sdram_dq_in <= '0;
    end
  end

  //////////////////////////////
  // Host driver
  initial
  begin
    int          n_req;
    int          gap;
    int          timeout;
    int          start_refs;
    logic [31:0] rnd;

    rst_n       = 1'b0;
    req         = 1'b0;
    req_data    = '0;
    exp_rdata   = '0;
    sdram_dq_in = '0;
    rnd         = 32'hbcb1_617a;

    $readmemh("verification/sdram_sched_stim.txt", stim_mem);
    n_req = 0;
    while (n_req < STIM_MAX && !$isunknown(stim_mem[6*n_req]))
      n_req++;
    if (n_req == 0)
      report_failure("Stimulus file holds no requests");

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);

    for (int i = 0; i < n_req; i++)
    begin
      req            <= 1'b1;
      req_data.we    <= stim_mem[6*i][0];
      req_data.ba    <= stim_mem[6*i+1][1:0];
      req_data.row   <= stim_mem[6*i+2][10:0];
      req_data.col   <= stim_mem[6*i+3][7:0];
      req_data.wdata <= stim_mem[6*i+4];
      exp_rdata      <= stim_mem[6*i+5];
      wait_for_ack(i);
      // Random idle gap between requests
      rnd = xorshift32(rnd);
      gap = rnd % 5;
      if (gap > 0)
      begin
        req <= 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    req <= 1'b0;

    timeout = 0;
    @(negedge clk);
    while (rd_due_q.size() != 0)
    begin
      timeout++;
      if (timeout > 4 * CAS_LATENCY + 8)
        report_failure("Read data still outstanding after the last request");
      @(negedge clk);
    end

    // Idle refreshes, the first one closing the rows left open
    start_refs = ref_cnt;
    timeout    = 0;
    while (ref_cnt < start_refs + 2)
    begin
      timeout++;
      if (timeout > 2 * (REFRESH_INTERVAL + 40))
        report_failure("Timeout waiting for refreshes on an idle bus");
      @(negedge clk);
    end

    if (pre_all_cnt > 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
      report_failure("No all-bank PRE seen ahead of a refresh");
  end

endmodule

`default_nettype wire

// ==== project.f ====
hw/sdram_sched_pkg.sv
hw/sdram_bank_timers.sv
hw/sdram_refresh_timer.sv
hw/sdram_bank_table.sv
hw/sdram_cmd_fsm.sv
hw/sdram_read_tracker.sv
hw/sdram_sched_top.sv
verification/tb_clock_gen.sv
verification/sdram_sched_tb.sv

// ==== verification/sdram_sched_stim.txt ====
// Columns (hex): we ba row col wdata expected_rdata
// One request per line, expected_rdata only matters for reads
1 0 012 10 1111 0000
1 0 012 11 2222 0000
1 1 0a0 05 3333 0000
1 0 055 20 4444 0000
0 0 012 10 0000 1111
0 0 012 11 0000 2222
0 1 0a0 05 0000 3333
0 0 055 20 0000 4444
1 2 7ff ff abcd 0000
1 3 400 00 0f0f 0000
1 2 7ff 80 beef 0000
0 3 400 00 0000 0f0f
0 2 7ff ff 0000 abcd
0 2 7ff 80 0000 beef
1 3 001 7e 1234 0000
0 3 001 7e 0000 1234
1 1 0a0 06 5678 0000
0 1 0a0 06 0000 5678
0 0 055 20 0000 4444
1 0 012 10 9abc 0000
0 0 012 10 0000 9abc
0 3 400 00 0000 0f0f
0 2 7ff ff 0000 abcd
